// ==== ispr_decode.sv ====
// ISPR address decoder
// Write strobes per register and the zero-extending read-back mux

`timescale 1ns/10ps

module ispr_decode
  import ntt_data_pkg::*;
  import ispr_pkg::*;
(
  input  ispr_addr_e addr_i,
  input  ispr_wr_t   wr_i,
  input  ntt_word_t  prime_i,
  input  ntt_word_t  prime_dash_i,
  input  ntt_word_t  twiddle_i,
  input  bank_data_t omega_words_i,
  input  bank_data_t psi_words_i,
  input  bank_idx_t  omega_idx_i,
  input  bank_idx_t  psi_idx_i,
  output ispr_wen_t  wen_o,
  output bank_data_t rdata_o
);

  always_comb begin
    wen_o = '0;
    if (wr_i.valid) begin
      case (addr_i)
        IsprPrime:     wen_o.prime      = 1'b1;
        IsprPrimeDash: wen_o.prime_dash = 1'b1;
        IsprTwiddle:   wen_o.twiddle    = 1'b1;
        IsprOmega:     wen_o.omega      = 1'b1;
        IsprPsi:       wen_o.psi        = 1'b1;
        IsprOmegaIdx:  wen_o.omega_idx  = 1'b1;
        IsprPsiIdx:    wen_o.psi_idx    = 1'b1;
        default:       wen_o = '0;
      endcase
      // A valid write must hit exactly one register
      assert ($onehot(wen_o))
        else $error("ispr_decode: valid write to an unmapped address");
    end
  end

  // Narrow registers read back zero-extended in word 0
  always_comb begin
    rdata_o = '0;
    case (addr_i)
      IsprPrime:     rdata_o[0] = prime_i;
      IsprPrimeDash: rdata_o[0] = prime_dash_i;
      IsprTwiddle:   rdata_o[0] = twiddle_i;
      IsprOmega:     rdata_o    = omega_words_i;
      IsprPsi:       rdata_o    = psi_words_i;
      IsprOmegaIdx:  rdata_o[0] = ntt_word_t'(omega_idx_i);
      IsprPsiIdx:    rdata_o[0] = ntt_word_t'(psi_idx_i);
      default:       rdata_o    = '0;
    endcase
  end

endmodule

// ==== ispr_pkg.sv ====
// ISPR register-access types
// Address map, write request and decoded write strobes

package ispr_pkg;

  import ntt_data_pkg::*;

  typedef enum logic [2:0] {
    IsprPrime     = 3'd0,
    IsprPrimeDash = 3'd1,
    IsprTwiddle   = 3'd2,
    IsprOmega     = 3'd3,
    IsprPsi       = 3'd4,
    IsprOmegaIdx  = 3'd5,
    IsprPsiIdx    = 3'd6
  } ispr_addr_e;

  // Single-cycle write, taken whenever valid is high
  typedef struct packed {
    logic       valid;
    word_mask_t word_en;
    bank_data_t wdata;
  } ispr_wr_t;

  typedef struct packed {
    logic prime;
    logic prime_dash;
    logic twiddle;
    logic omega;
    logic psi;
    logic omega_idx;
    logic psi_idx;
  } ispr_wen_t;

  // Operation pulses
  typedef struct packed {
    logic update_twiddle;
    logic update_omega;
    logic update_psi;
    logic set_twiddle_as_psi;
    logic invert_twiddle;
    logic omega_idx_inc;
    logic psi_idx_inc;
  } twiddle_op_t;

endpackage

// ==== montgomery_mul.sv ====
// Montgomery modular multiplier
// Combinational a * b * 2^-LOG_R mod q with final conditional subtract

`timescale 1ns/10ps

`include "twiddle_consts.svh"

module montgomery_mul (
  input  logic [`PQLEN-1:0] a_i,
  input  logic [`PQLEN-1:0] b_i,
  input  logic [`PQLEN-1:0] q_i,
  input  logic [`PQLEN-1:0] q_dash_i,
  output logic [`PQLEN-1:0] res_o
);

  logic [2*`PQLEN-1:0] a_ext;
  logic [2*`PQLEN-1:0] b_ext;
  logic [2*`PQLEN-1:0] q_ext;
  logic [2*`PQLEN-1:0] t;
  logic [`LOG_R-1:0]   m;
  logic [2*`PQLEN-1:0] m_ext;
  logic [2*`PQLEN-1:0] mq;
  logic [2*`PQLEN:0]   sum;
  logic [`PQLEN:0]     u;
  logic [`PQLEN:0]     u_sub;

  assign a_ext = {{`PQLEN{1'b0}}, a_i};
  assign b_ext = {{`PQLEN{1'b0}}, b_i};
  assign q_ext = {{`PQLEN{1'b0}}, q_i};

  // Full product
  assign t = a_ext * b_ext;

  // m = t * q' mod R
  assign m = t[`LOG_R-1:0] * q_dash_i;

  assign m_ext = {{(2*`PQLEN-`LOG_R){1'b0}}, m};
  assign mq    = m_ext * q_ext;

  // t + m*q is a multiple of R, so the low half drops out exactly
  assign sum = {1'b0, t} + {1'b0, mq};
  assign u   = sum[2*`PQLEN:`LOG_R];

  assign u_sub = u - {1'b0, q_i};

  // u < 2q, one subtraction is enough
  assign res_o = (u >= {1'b0, q_i}) ? u_sub[`PQLEN-1:0] : u[`PQLEN-1:0];

endmodule

// ==== ntt_data_pkg.sv ====
// NTT arithmetic data types
// Residue words, root banks, bank indices and word masks

`include "twiddle_consts.svh"

package ntt_data_pkg;

  // One residue modulo the prime
  typedef logic [`PQLEN-1:0] ntt_word_t;

  // Eight residues, word 0 in the low bits
  typedef ntt_word_t [`BANK_WORDS-1:0] bank_data_t;

  // Position within a bank
  typedef logic [`BANK_IDX_W-1:0] bank_idx_t;

  // One enable per 32-bit word
  typedef logic [`BANK_WORDS-1:0] word_mask_t;

endpackage

// ==== root_bank.sv ====
// Eight-word root bank
// Masked ISPR writes, indexed update and a wrapping word index

`timescale 1ns/10ps

`include "twiddle_consts.svh"

module root_bank
  import ntt_data_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       init_i,
  input  logic       wr_en_i,
  input  word_mask_t word_en_i,
  input  bank_data_t wdata_i,
  input  logic       idx_wr_en_i,
  input  bank_idx_t  idx_wdata_i,
  input  logic       upd_en_i,
  input  ntt_word_t  upd_word_i,
  input  logic       idx_inc_i,
  output ntt_word_t  cur_o,
  output bank_data_t words_o,
  output bank_idx_t  idx_o
);

  bank_data_t words_q;
  bank_idx_t  idx_q;

  for (genvar i = 0; i < `BANK_WORDS; i++) begin : g_word
    always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
        words_q[i] <= '0;
      end else if (init_i) begin
        words_q[i] <= '0;
      end else if (wr_en_i && word_en_i[i]) begin
        words_q[i] <= wdata_i[i];
      end else if (upd_en_i && (idx_q == bank_idx_t'(i))) begin
        words_q[i] <= upd_word_i;
      end
    end
  end

  // Index wraps modulo 8 through its width
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      idx_q <= '0;
    end else if (init_i) begin
      idx_q <= '0;
    end else if (idx_wr_en_i) begin
      idx_q <= idx_wdata_i;
    end else if (idx_inc_i) begin
      idx_q <= idx_q + 1'b1;
    end
  end

  assign cur_o   = words_q[idx_q];
  assign words_o = words_q;
  assign idx_o   = idx_q;

  // A masked ISPR write and an op update never land in the same cycle
  a_no_wr_upd_clash : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(wr_en_i && upd_en_i)
  ) else $error("root_bank: ISPR write and update in the same cycle");

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the twiddle unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f \
  --top-module tb_twiddle_unit -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qx "Result: PASSED"; then
  exit 0
fi
exit 1

// ==== tb.f ====
+incdir+.
ntt_data_pkg.sv
ispr_pkg.sv
montgomery_mul.sv
root_bank.sv
twiddle_datapath.sv
ispr_decode.sv
twiddle_unit_top.sv
tb_twiddle_unit.sv

// ==== tb_twiddle_unit.sv ====
// Testbench for the twiddle-factor unit
// LFSR-driven random ISPR writes, ops and inits checked against a reference model

`timescale 1ns/10ps

`include "twiddle_consts.svh"

module tb_twiddle_unit
  import ntt_data_pkg::*;
  import ispr_pkg::*;
();

  localparam int     num_cycles  = 4000;
  localparam int     extra_cycles = 32;
  localparam longint watchdog_ns = longint'(num_cycles + extra_cycles) * 20 + 10 * 10;

  logic        clk_i;
  logic        rst_n_i;
  logic        ispr_init_i;
  ispr_addr_e  ispr_addr_i;
  ispr_wr_t    ispr_wr_i;
  twiddle_op_t op_i;
  bank_data_t  ispr_rdata_o;
  ntt_word_t   twiddle_o;
  ntt_word_t   omega_o;
  ntt_word_t   psi_o;
  ntt_word_t   prime_o;
  ntt_word_t   prime_dash_o;

  // Reference model state
  ntt_word_t   m_prime;
  ntt_word_t   m_prime_dash;
  ntt_word_t   m_twiddle;
  bank_data_t  m_omega;
  bank_data_t  m_psi;
  bank_idx_t   m_omega_idx;
  bank_idx_t   m_psi_idx;
  logic [31:0] lfsr_state;

  twiddle_unit_top i_dut (.*);

  always #5 clk_i = ~clk_i;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[30:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // -q^-1 mod 2^32, each Newton step doubles the valid low bits
  function automatic ntt_word_t neg_inverse(input ntt_word_t q);
    ntt_word_t x;
    x = q;
    for (int i = 0; i < 4; i++) begin
      x = x * (32'd2 - q * x);
    end
    return -x;
  endfunction

  // REDC: (t + m*q) / 2^32 with one conditional subtract
  function automatic ntt_word_t mont_model(input ntt_word_t a, input ntt_word_t b,
                                           input ntt_word_t q, input ntt_word_t qd);
    logic [63:0] t;
    logic [31:0] m;
    logic [64:0] s;
    logic [32:0] u;
    t = 64'(a) * 64'(b);
    m = t[31:0] * qd;
    s = 65'(t) + 65'(64'(m) * 64'(q));
    u = s[64:32];
    if (u >= 33'(q)) u = u - 33'(q);
    return u[31:0];
  endfunction

  function automatic ispr_wr_t make_write(input ispr_addr_e addr);
    ispr_wr_t wr;
    wr.valid   = 1'b1;
    wr.word_en = word_mask_t'(rand_bits(8));
    for (int i = 0; i < `BANK_WORDS; i++) begin
      wr.wdata[i] = rand_bits(32);
      if (m_prime != 0 && addr inside {IsprTwiddle, IsprOmega, IsprPsi}) begin
        wr.wdata[i] = wr.wdata[i] % m_prime;
      end
    end
    // Odd primes below 2^31
    if (addr == IsprPrime) wr.wdata[0] = {1'b0, wr.wdata[0][30:1], 1'b1};
    if (addr == IsprPrimeDash) wr.wdata[0] = neg_inverse(m_prime);
    return wr;
  endfunction

  function automatic bank_data_t expected_rdata(input ispr_addr_e addr);
    bank_data_t d;
    d = '0;
    case (addr)
      IsprPrime:     d[0] = m_prime;
      IsprPrimeDash: d[0] = m_prime_dash;
      IsprTwiddle:   d[0] = m_twiddle;
      IsprOmega:     d    = m_omega;
      IsprPsi:       d    = m_psi;
      IsprOmegaIdx:  d[0] = {29'd0, m_omega_idx};
      IsprPsiIdx:    d[0] = {29'd0, m_psi_idx};
      default:       d    = '0;
    endcase
    return d;
  endfunction

  task automatic model_clear();
    m_prime      = '0;
    m_prime_dash = '0;
    m_twiddle    = '0;
    m_omega      = '0;
    m_psi        = '0;
    m_omega_idx  = '0;
    m_psi_idx    = '0;
  endtask

  // Init beats ISPR write beats operation
  task automatic apply_model(input ispr_addr_e addr, input ispr_wr_t wr,
                             input logic init, input twiddle_op_t op);
    ntt_word_t w_om;
    w_om = m_omega[m_omega_idx];
    if (init) begin
      model_clear();
    end else if (wr.valid) begin
      case (addr)
        IsprPrime:     if (wr.word_en[0]) m_prime = wr.wdata[0];
        IsprPrimeDash: if (wr.word_en[0]) m_prime_dash = wr.wdata[0];
        IsprTwiddle:   if (wr.word_en[0]) m_twiddle = wr.wdata[0];
        IsprOmegaIdx:  if (wr.word_en[0]) m_omega_idx = wr.wdata[0][2:0];
        IsprPsiIdx:    if (wr.word_en[0]) m_psi_idx = wr.wdata[0][2:0];
        default: begin
          for (int i = 0; i < `BANK_WORDS; i++) begin
            if (wr.word_en[i] && addr == IsprOmega) m_omega[i] = wr.wdata[i];
            if (wr.word_en[i] && addr == IsprPsi) m_psi[i] = wr.wdata[i];
          end
        end
      endcase
    end else begin
      if (op.update_twiddle) m_twiddle = mont_model(m_twiddle, w_om, m_prime, m_prime_dash);
      if (op.update_omega) m_omega[m_omega_idx] = mont_model(w_om, w_om, m_prime, m_prime_dash);
      if (op.update_psi) m_psi[m_psi_idx] = w_om;
      if (op.set_twiddle_as_psi) m_twiddle = m_psi[m_psi_idx];
      if (op.invert_twiddle) m_twiddle = m_prime - m_twiddle;
      if (op.omega_idx_inc) m_omega_idx = m_omega_idx + 3'd1;
      if (op.psi_idx_inc) m_psi_idx = m_psi_idx + 3'd1;
    end
  endtask

  task automatic check_word(input string what, input ntt_word_t got, input ntt_word_t exp);
    if (got !== exp) begin
      $display("FAIL at time %0t: %s is %h, expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic check_rdata(input ispr_addr_e addr, input bank_data_t got,
                             input bank_data_t exp);
    if (got !== exp) begin
      $display("FAIL at time %0t: rdata for %s is %h, expected %h",
               $time, addr.name(), got, exp);
      $display("Result: FAILED");
      $fatal(1, "read-back mismatch");
    end
  endtask

  task automatic check_outputs();
    check_word("twiddle_o", twiddle_o, m_twiddle);
    check_word("omega_o", omega_o, m_omega[m_omega_idx]);
    check_word("psi_o", psi_o, m_psi[m_psi_idx]);
    check_word("prime_o", prime_o, m_prime);
    check_word("prime_dash_o", prime_dash_o, m_prime_dash);
    check_rdata(ispr_addr_i, ispr_rdata_o, expected_rdata(ispr_addr_i));
  endtask

  // Outputs are settled at the falling edge, new inputs go out right after
  task automatic run_cycle(input ispr_addr_e addr, input ispr_wr_t wr,
                           input logic init, input twiddle_op_t op);
    @(negedge clk_i);
    check_outputs();
    ispr_addr_i = addr;
    ispr_wr_i   = wr;
    ispr_init_i = init;
    op_i        = op;
    apply_model(addr, wr, init, op);
  endtask

  task automatic random_cycle();
    ispr_addr_e  addr;
    ispr_wr_t    wr;
    logic        init;
    twiddle_op_t op;
    logic [3:0]  act;
    addr = ispr_addr_e'(3'(rand_bits(3) % 7));
    wr   = '0;
    init = 1'b0;
    op   = '0;
    act  = 4'(rand_bits(4));
    if (act < 7) begin
      wr = make_write(addr);
    end else if (act < 14) begin
      op = twiddle_op_t'(7'b1 << (rand_bits(3) % 7));
    end else if (act == 14) begin
      init = 1'b1;
      if (rand_bits(1) == 1) wr = make_write(addr);
    end
    run_cycle(addr, wr, init, op);
  endtask

  task automatic read_sweep();
    for (int a = 0; a < 7; a++) begin
      run_cycle(ispr_addr_e'(3'(a)), '0, 1'b0, '0);
    end
  endtask

  initial begin
    ispr_wr_t wr;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    ispr_init_i = 1'b0;
    ispr_addr_i = IsprPrime;
    ispr_wr_i   = '0;
    op_i        = '0;
    lfsr_state  = 32'h851f_dff7;
    model_clear();
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
    read_sweep();
    for (int n = 0; n < num_cycles; n++) begin
      random_cycle();
    end
    // Full write together with init, init must win
    wr = make_write(IsprOmega);
    wr.word_en = '1;
    run_cycle(IsprOmega, wr, 1'b1, '0);
    read_sweep();
    @(negedge clk_i);
    check_outputs();
    $display("Result: PASSED");
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("Watchdog expired: the test did not reach its end in time");
    $display("Result: FAILED");
    $fatal(1, "timeout");
  end

endmodule

// ==== twiddle_consts.svh ====
// Twiddle unit constants
// Word, bank and ISPR widths shared by packages and RTL

`ifndef TWIDDLE_CONSTS_SVH
`define TWIDDLE_CONSTS_SVH

// Residue word width
`define PQLEN 32

// Words per root bank
`define BANK_WORDS 8

// Bank index width, log2 of BANK_WORDS
`define BANK_IDX_W 3

// Montgomery radix R = 2^LOG_R
`define LOG_R 32

// Full ISPR data width
`define ISPR_W 256

`endif

// ==== twiddle_datapath.sv ====
// Twiddle datapath
// Prime, prime_dash and twiddle registers with both Montgomery products

`timescale 1ns/10ps

module twiddle_datapath
  import ntt_data_pkg::*;
  import ispr_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        init_i,
  input  ispr_wen_t   wen_i,
  input  ispr_wr_t    ispr_wr_i,
  input  twiddle_op_t op_i,
  input  ntt_word_t   omega_i,
  input  ntt_word_t   psi_i,
  output ntt_word_t   prime_o,
  output ntt_word_t   prime_dash_o,
  output ntt_word_t   twiddle_o,
  output ntt_word_t   omega_sq_o
);

  ntt_word_t prime_q;
  ntt_word_t prime_dash_q;
  ntt_word_t twiddle_q;
  ntt_word_t twiddle_d;
  ntt_word_t twiddle_mul;
  ntt_word_t wdata_w0;
  logic      w0_en;

  // Narrow registers only see word 0
  assign wdata_w0 = ispr_wr_i.wdata[0];
  assign w0_en    = ispr_wr_i.word_en[0];

  montgomery_mul u_mul_twiddle (
    .a_i      (twiddle_q),
    .b_i      (omega_i),
    .q_i      (prime_q),
    .q_dash_i (prime_dash_q),
    .res_o    (twiddle_mul)
  );

  montgomery_mul u_mul_omega (
    .a_i      (omega_i),
    .b_i      (omega_i),
    .q_i      (prime_q),
    .q_dash_i (prime_dash_q),
    .res_o    (omega_sq_o)
  );

  always_comb begin
    twiddle_d = twiddle_q;
    if (init_i) begin
      twiddle_d = '0;
    end else if (wen_i.twiddle && w0_en) begin
      twiddle_d = wdata_w0;
    end else if (op_i.update_twiddle) begin
      twiddle_d = twiddle_mul;
    end else if (op_i.invert_twiddle) begin
      twiddle_d = prime_q - twiddle_q;
    end else if (op_i.set_twiddle_as_psi) begin
      twiddle_d = psi_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      prime_q      <= '0;
      prime_dash_q <= '0;
      twiddle_q    <= '0;
    end else begin
      if (init_i) begin
        prime_q      <= '0;
        prime_dash_q <= '0;
      end else begin
        if (wen_i.prime && w0_en) prime_q <= wdata_w0;
        if (wen_i.prime_dash && w0_en) prime_dash_q <= wdata_w0;
      end
      twiddle_q <= twiddle_d;
    end
  end

  assign prime_o      = prime_q;
  assign prime_dash_o = prime_dash_q;
  assign twiddle_o    = twiddle_q;

  // At most one op or ISPR write per cycle across the whole unit
  a_op_onehot : assert property (
    @(posedge clk_i) disable iff (!rst_n_i) $onehot0({op_i, ispr_wr_i.valid})
  ) else $error("twiddle_datapath: overlapping operations or ISPR write");

endmodule

// ==== twiddle_unit_top.sv ====
// Twiddle-factor unit for NTT
// ISPR decode, twiddle datapath and the omega and psi root banks

`timescale 1ns/10ps

`include "twiddle_consts.svh"

module twiddle_unit_top
  import ntt_data_pkg::*;
  import ispr_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  ispr_addr_e  ispr_addr_i,
  input  ispr_wr_t    ispr_wr_i,
  input  logic        ispr_init_i,
  input  twiddle_op_t op_i,
  output bank_data_t  ispr_rdata_o,
  output ntt_word_t   twiddle_o,
  output ntt_word_t   omega_o,
  output ntt_word_t   psi_o,
  output ntt_word_t   prime_o,
  output ntt_word_t   prime_dash_o
);

  ispr_wen_t  wen;
  ntt_word_t  omega_sq;
  bank_data_t omega_words;
  bank_data_t psi_words;
  bank_idx_t  omega_idx;
  bank_idx_t  psi_idx;
  bank_idx_t  idx_wdata;
  logic       w0_en;

  // Index registers take bits 2:0 of word 0
  assign idx_wdata = ispr_wr_i.wdata[0][`BANK_IDX_W-1:0];
  assign w0_en     = ispr_wr_i.word_en[0];

  ispr_decode u_ispr_decode (
    .addr_i        (ispr_addr_i),
    .wr_i          (ispr_wr_i),
    .prime_i       (prime_o),
    .prime_dash_i  (prime_dash_o),
    .twiddle_i     (twiddle_o),
    .omega_words_i (omega_words),
    .psi_words_i   (psi_words),
    .omega_idx_i   (omega_idx),
    .psi_idx_i     (psi_idx),
    .wen_o         (wen),
    .rdata_o       (ispr_rdata_o)
  );

  twiddle_datapath u_datapath (
    .clk_i, .rst_n_i,
    .init_i       (ispr_init_i),
    .wen_i        (wen),
    .ispr_wr_i    (ispr_wr_i),
    .op_i         (op_i),
    .omega_i      (omega_o),
    .psi_i        (psi_o),
    .prime_o      (prime_o),
    .prime_dash_o (prime_dash_o),
    .twiddle_o    (twiddle_o),
    .omega_sq_o   (omega_sq)
  );

  // Omega updates with its own square
  root_bank u_omega_bank (
    .clk_i, .rst_n_i,
    .init_i (ispr_init_i),
    .wr_en_i (wen.omega), .word_en_i (ispr_wr_i.word_en), .wdata_i (ispr_wr_i.wdata),
    .idx_wr_en_i (wen.omega_idx && w0_en), .idx_wdata_i (idx_wdata),
    .upd_en_i (op_i.update_omega), .upd_word_i (omega_sq),
    .idx_inc_i (op_i.omega_idx_inc),
    .cur_o (omega_o), .words_o (omega_words), .idx_o (omega_idx)
  );

  // Psi takes the current omega word
  root_bank u_psi_bank (
    .clk_i, .rst_n_i,
    .init_i (ispr_init_i),
    .wr_en_i (wen.psi), .word_en_i (ispr_wr_i.word_en), .wdata_i (ispr_wr_i.wdata),
    .idx_wr_en_i (wen.psi_idx && w0_en), .idx_wdata_i (idx_wdata),
    .upd_en_i (op_i.update_psi), .upd_word_i (omega_o),
    .idx_inc_i (op_i.psi_idx_inc),
    .cur_o (psi_o), .words_o (psi_words), .idx_o (psi_idx)
  );

endmodule
